// ==== build.f ====
+incdir+hdl
+incdir+verif
hdl/rvIsaPkg.sv
hdl/pipePkg.sv
hdl/decodeUnit.sv
hdl/regFile.sv
hdl/hazardUnit.sv
hdl/executeUnit.sv
hdl/dataMem.sv
hdl/rvPipeCore.sv
verif/rvTestbench.sv

// ==== hdl/dataMem.sv ====
`timescale 1ns/1ps
`include "rv_params.svh"

module dataMem (
  input  logic             clk,
  input  logic             reset,
  input  logic             we,
  input  logic [`XLEN-1:0] addr,
  input  logic [`XLEN-1:0] wd,
  output logic [`XLEN-1:0] rd
);

  localparam int AW = $clog2(`DMEM_WORDS);  // Word index width

  logic [`XLEN-1:0] mem [`DMEM_WORDS];
  logic [AW-1:0]    wordIdx;

  assign wordIdx = addr[AW+1:2];   // Byte address to word
  assign rd      = mem[wordIdx];   // Read in the same cycle

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < `DMEM_WORDS; i++) mem[i] <= '0;
    end else if (we) begin
      mem[wordIdx] <= wd;
    end
  end

  // Stores come from the pipeline with aligned in-range addresses
  assert property (@(posedge clk) disable iff (reset)
    we |-> (addr[1:0] == 2'b00 && addr < 4 * `DMEM_WORDS));

endmodule

// ==== hdl/decodeUnit.sv ====
`timescale 1ns/1ps
`include "rv_params.svh"

module decodeUnit
  import rvIsaPkg::*, pipePkg::*;
(
  input  instrU            instr,
  output ctrlT             ctrl,
  output logic [`XLEN-1:0] imm
);

  immSelT immSel;
  aluOpT  aluFn;   // ALU op from funct fields

  // ==========================================================================
  // Main decoder
  // ==========================================================================
  always_comb begin
    ctrl   = '0;     // Inactive bundle unless opcode known
    immSel = immI;
    case (instr.r.opcode)
      opLoad: begin
        ctrl.regWrite  = 1'b1;
        ctrl.resultSel = resMem;
        ctrl.aluSrcImm = 1'b1;  // Base plus offset
      end
      opStore: begin
        ctrl.memWrite  = 1'b1;
        ctrl.aluSrcImm = 1'b1;
        immSel         = immS;
      end
      opReg: begin
        ctrl.regWrite = 1'b1;
        ctrl.aluOp    = aluFn;
      end
      opImm: begin
        ctrl.regWrite  = 1'b1;
        ctrl.aluOp     = aluFn;
        ctrl.aluSrcImm = 1'b1;
      end
      opBranch: begin
        ctrl.branch = 1'b1;
        ctrl.aluOp  = aluSub;   // Equal when difference is zero
        immSel      = immB;
      end
      opJal: begin
        ctrl.regWrite  = 1'b1;
        ctrl.resultSel = resPcPlus4;  // Link value
        ctrl.jump      = 1'b1;
        immSel         = immJ;
      end
      default: ;
    endcase
  end

  // ALU decoder
  always_comb begin
    case (instr.r.funct3)
      3'b000: begin
        // Sub only exists in R-type
        if (instr.r.opcode == opReg && instr.r.funct7[5])
          aluFn = aluSub;
        else
          aluFn = aluAdd;
      end
      3'b010:  aluFn = aluSlt;
      3'b110:  aluFn = aluOr;
      3'b111:  aluFn = aluAnd;
      default: aluFn = aluAdd;
    endcase
  end

  // ==========================================================================
  // Immediate extension
  // ==========================================================================
  always_comb begin
    case (immSel)
      immS: imm = {{(`XLEN-12){instr.s.immHi[6]}}, instr.s.immHi, instr.s.immLo};
      immB: imm = {{(`XLEN-12){instr.b.imm12}}, instr.b.imm11, instr.b.imm10to5,
                   instr.b.imm4to1, 1'b0};
      immJ: imm = {{(`XLEN-20){instr.j.imm20}}, instr.j.imm19to12, instr.j.imm11,
                   instr.j.imm10to1, 1'b0};
      default: imm = {{(`XLEN-12){instr.i.imm[11]}}, instr.i.imm};  // I format
    endcase
  end

endmodule

// ==== hdl/executeUnit.sv ====
`timescale 1ns/1ps
`include "rv_params.svh"

module executeUnit
  import rvIsaPkg::*, pipePkg::*;
(
  input  exeRegT           ex,
  input  fwdSelT           fwdA,
  input  fwdSelT           fwdB,
  input  logic [`XLEN-1:0] resultM,
  input  logic [`XLEN-1:0] resultW,
  output logic [`XLEN-1:0] aluResult,
  output logic [`XLEN-1:0] storeData,
  output logic [`XLEN-1:0] target,
  output logic             zero
);

  logic [`XLEN-1:0] srcA, srcB;
  logic [`XLEN-1:0] bOperand, sum;
  logic             subOp;
  logic             overflow;

  function automatic logic [`XLEN-1:0] fwdMux(input fwdSelT sel,
                                               input logic [`XLEN-1:0] regVal,
                                               input logic [`XLEN-1:0] memVal,
                                               input logic [`XLEN-1:0] wbVal);
    case (sel)
      fwdFromMem: return memVal;
      fwdFromWb:  return wbVal;
      default:    return regVal;
    endcase
  endfunction

  // ==========================================================================
  // Operand select
  // ==========================================================================
  assign srcA      = fwdMux(fwdA, ex.rd1, resultM, resultW);
  assign storeData = fwdMux(fwdB, ex.rd2, resultM, resultW);  // Also sw data
  assign srcB      = ex.ctrl.aluSrcImm ? ex.imm : storeData;

  // Shared adder for add, sub and slt
  assign subOp    = (ex.ctrl.aluOp == aluSub) || (ex.ctrl.aluOp == aluSlt);
  assign bOperand = subOp ? ~srcB : srcB;
  assign sum      = srcA + bOperand + {{(`XLEN-1){1'b0}}, subOp};
  // Signed overflow of a + b or a - b
  assign overflow = ~(subOp ^ srcA[`XLEN-1] ^ srcB[`XLEN-1]) &
                    (srcA[`XLEN-1] ^ sum[`XLEN-1]);

  always_comb begin
    case (ex.ctrl.aluOp)
      aluAnd:  aluResult = srcA & srcB;
      aluOr:   aluResult = srcA | srcB;
      aluSlt:  aluResult = {{(`XLEN-1){1'b0}}, sum[`XLEN-1] ^ overflow};
      default: aluResult = sum;   // add and sub
    endcase
  end

  assign zero   = (aluResult == '0);   // beq compare
  assign target = ex.pc + ex.imm;      // Branch or jal destination

endmodule

// ==== hdl/hazardUnit.sv ====
`timescale 1ns/1ps

module hazardUnit
  import pipePkg::*;
(
  input  logic [4:0] rs1D,
  input  logic [4:0] rs2D,
  input  logic [4:0] rs1E,
  input  logic [4:0] rs2E,
  input  logic [4:0] rdE,
  input  logic [4:0] rdM,
  input  logic [4:0] rdW,
  input  logic       loadE,
  input  logic       regWriteM,
  input  logic       regWriteW,
  input  logic       taken,
  output fwdSelT     fwdA,
  output fwdSelT     fwdB,
  output logic       stallF,
  output logic       stallD,
  output logic       flushD,
  output logic       flushE
);

  logic loadStall;

  // Newest writer wins
  function automatic fwdSelT pickFwd(input logic [4:0] rs);
    if (rs == 5'd0)                    return fwdNone;     // x0 never forwarded
    else if (regWriteM && rs == rdM)   return fwdFromMem;
    else if (regWriteW && rs == rdW)   return fwdFromWb;
    else                               return fwdNone;
  endfunction

  always_comb begin
    fwdA = pickFwd(rs1E);
    fwdB = pickFwd(rs2E);
  end

  // Load result only exists after memory stage
  assign loadStall = loadE && rdE != 5'd0 && (rs1D == rdE || rs2D == rdE);

  assign stallF = loadStall;
  assign stallD = loadStall;
  assign flushD = taken;
  assign flushE = loadStall || taken;  // Bubble into execute

  // Load and branch are never the same execute instruction
  always_comb begin
    assert final (!(stallD === 1'b1 && flushD === 1'b1));
  end

endmodule

// ==== hdl/pipePkg.sv ====
`include "rv_params.svh"

package pipePkg;
  import rvIsaPkg::*;

  // ==========================================================================
  // Control and select encodings
  // ==========================================================================
  typedef enum logic [1:0] {resAlu, resMem, resPcPlus4} resultSelT;

  // Operand source in execute
  typedef enum logic [1:0] {fwdNone, fwdFromWb, fwdFromMem} fwdSelT;

  typedef struct packed {
    logic      regWrite;
    resultSelT resultSel;
    logic      memWrite;
    logic      branch;     // beq
    logic      jump;       // jal
    aluOpT     aluOp;
    logic      aluSrcImm;  // Immediate as second operand
  } ctrlT;

  // ==========================================================================
  // Stage registers
  // ==========================================================================
  typedef struct packed {
    instrU             instr;
    logic [`XLEN-1:0]  pc;
    logic [`XLEN-1:0]  pcPlus4;
  } decRegT;

  typedef struct packed {
    ctrlT              ctrl;
    logic [`XLEN-1:0]  rd1;
    logic [`XLEN-1:0]  rd2;
    logic [`XLEN-1:0]  pc;
    logic [`XLEN-1:0]  imm;
    logic [4:0]        rs1;
    logic [4:0]        rs2;
    logic [4:0]        rd;
    logic [`XLEN-1:0]  pcPlus4;
  } exeRegT;

  typedef struct packed {
    logic              regWrite;
    resultSelT         resultSel;
    logic              memWrite;
    logic [`XLEN-1:0]  aluResult;  // Also the store address
    logic [`XLEN-1:0]  writeData;
    logic [4:0]        rd;
    logic [`XLEN-1:0]  pcPlus4;
  } memRegT;

  typedef struct packed {
    logic              regWrite;
    resultSelT         resultSel;
    logic [`XLEN-1:0]  aluResult;
    logic [`XLEN-1:0]  readData;
    logic [4:0]        rd;
    logic [`XLEN-1:0]  pcPlus4;
  } wbRegT;

endpackage

// ==== hdl/regFile.sv ====
`timescale 1ns/1ps
`include "rv_params.svh"

module regFile (
  input  logic             clk,
  input  logic             we,
  input  logic [4:0]       ra1,
  input  logic [4:0]       ra2,
  input  logic [4:0]       wa,
  input  logic [`XLEN-1:0] wd,
  output logic [`XLEN-1:0] rd1,
  output logic [`XLEN-1:0] rd2
);

  logic [`XLEN-1:0] regs [`NREGS];

  // One read port with x0 and the write bypass
  function automatic logic [`XLEN-1:0] readPort(input logic [4:0] ra);
    if (ra == 5'd0)
      return '0;
    else if (we && ra == wa)
      return wd;           // Value written this cycle
    else
      return regs[ra];
  endfunction

  always_ff @(posedge clk) begin
    if (we && wa != 5'd0) regs[wa] <= wd;  // x0 never stored
  end

  always_comb begin
    rd1 = readPort(ra1);
    rd2 = readPort(ra2);
  end

endmodule

// ==== hdl/rvIsaPkg.sv ====
package rvIsaPkg;

  // ==========================================================================
  // Opcodes of the supported integer subset
  // ==========================================================================
  typedef enum logic [6:0] {
    opLoad   = 7'b0000011,  // lw
    opStore  = 7'b0100011,  // sw
    opReg    = 7'b0110011,  // add sub and or slt
    opImm    = 7'b0010011,  // addi andi ori slti
    opBranch = 7'b1100011,  // beq
    opJal    = 7'b1101111
  } opcodeT;

  // Field layouts, msb first
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    opcodeT     opcode;
  } rTypeT;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    opcodeT      opcode;
  } iTypeT;

  typedef struct packed {
    logic [6:0] immHi;   // imm[11:5]
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] immLo;   // imm[4:0]
    opcodeT     opcode;
  } sTypeT;

  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10to5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm4to1;
    logic       imm11;
    opcodeT     opcode;
  } bTypeT;

  typedef struct packed {
    logic       imm20;
    logic [9:0] imm10to1;
    logic       imm11;
    logic [7:0] imm19to12;
    logic [4:0] rd;
    opcodeT     opcode;
  } jTypeT;

  // One instruction word, five views
  typedef union packed {
    rTypeT r;
    iTypeT i;
    sTypeT s;
    bTypeT b;
    jTypeT j;
  } instrU;

  // ALU operations actually produced by the decoder
  typedef enum logic [2:0] {
    aluAdd = 3'd0,
    aluSub = 3'd1,
    aluAnd = 3'd2,
    aluOr  = 3'd3,
    aluSlt = 3'd4
  } aluOpT;

  // Immediate formats
  typedef enum logic [1:0] {immI, immS, immB, immJ} immSelT;

endpackage

// ==== hdl/rvPipeCore.sv ====
`timescale 1ns/1ps
`include "rv_params.svh"

module rvPipeCore
  import pipePkg::*;
(
  input  logic             clk,
  input  logic             reset,
  output logic [`XLEN-1:0] pc,
  input  logic [`XLEN-1:0] instr,
  output logic             memWrite,
  output logic [`XLEN-1:0] dataAdr,
  output logic [`XLEN-1:0] writeData
);

  decRegT decR;
  exeRegT exeR;
  memRegT memR;
  wbRegT  wbR;

  ctrlT             ctrlD;
  logic [`XLEN-1:0] immD, rd1D, rd2D;
  logic [`XLEN-1:0] pcPlus4F, pcNext;
  logic [`XLEN-1:0] aluResultE, storeDataE, targetE;
  logic [`XLEN-1:0] readDataM, resultW;
  logic             zeroE, taken, loadE;
  logic             stallF, stallD, flushD, flushE;
  fwdSelT           fwdA, fwdB;

  // ==========================================================================
  // Fetch
  // ==========================================================================
  assign pcPlus4F = pc + `XLEN'd4;
  assign pcNext   = taken ? targetE : pcPlus4F;  // Redirect from execute

  always_ff @(posedge clk or posedge reset) begin
    if (reset)        pc <= '0;
    else if (!stallF) pc <= pcNext;
  end

  // Decode register, flush beats stall
  always_ff @(posedge clk or posedge reset) begin
    if (reset)        decR <= '0;
    else if (flushD)  decR <= '0;
    else if (!stallD) decR <= '{instr: instr, pc: pc, pcPlus4: pcPlus4F};
  end

  // ==========================================================================
  // Decode
  // ==========================================================================
  decodeUnit decode0 (.instr(decR.instr), .ctrl(ctrlD), .imm(immD));

  regFile regs0 (
    .clk(clk), .we(wbR.regWrite),
    .ra1(decR.instr.r.rs1), .ra2(decR.instr.r.rs2), .wa(wbR.rd),
    .wd(resultW), .rd1(rd1D), .rd2(rd2D)
  );

  always_ff @(posedge clk or posedge reset) begin
    if (reset)       exeR <= '0;
    else if (flushE) exeR <= '0;    // Bubble
    else exeR <= '{ctrl: ctrlD, rd1: rd1D, rd2: rd2D, pc: decR.pc, imm: immD,
                   rs1: decR.instr.r.rs1, rs2: decR.instr.r.rs2,
                   rd: decR.instr.r.rd, pcPlus4: decR.pcPlus4};
  end

  // ==========================================================================
  // Execute and hazards
  // ==========================================================================
  executeUnit exec0 (
    .ex(exeR), .fwdA(fwdA), .fwdB(fwdB),
    .resultM(memR.aluResult), .resultW(resultW),
    .aluResult(aluResultE), .storeData(storeDataE), .target(targetE), .zero(zeroE)
  );

  assign taken = (exeR.ctrl.branch & zeroE) | exeR.ctrl.jump;
  assign loadE = (exeR.ctrl.resultSel == resMem);

  hazardUnit hazard0 (
    .rs1D(decR.instr.r.rs1), .rs2D(decR.instr.r.rs2),
    .rs1E(exeR.rs1), .rs2E(exeR.rs2), .rdE(exeR.rd), .rdM(memR.rd), .rdW(wbR.rd),
    .loadE(loadE), .regWriteM(memR.regWrite), .regWriteW(wbR.regWrite), .taken(taken),
    .fwdA(fwdA), .fwdB(fwdB),
    .stallF(stallF), .stallD(stallD), .flushD(flushD), .flushE(flushE)
  );

  always_ff @(posedge clk or posedge reset) begin
    if (reset) memR <= '0;
    else memR <= '{regWrite: exeR.ctrl.regWrite, resultSel: exeR.ctrl.resultSel,
                   memWrite: exeR.ctrl.memWrite, aluResult: aluResultE,
                   writeData: storeDataE, rd: exeR.rd, pcPlus4: exeR.pcPlus4};
  end

  // Memory stage
  dataMem dmem0 (
    .clk(clk), .reset(reset), .we(memR.memWrite),
    .addr(memR.aluResult), .wd(memR.writeData), .rd(readDataM)
  );

  assign memWrite  = memR.memWrite;   // Store visible at the ports
  assign dataAdr   = memR.aluResult;
  assign writeData = memR.writeData;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) wbR <= '0;
    else wbR <= '{regWrite: memR.regWrite, resultSel: memR.resultSel,
                  aluResult: memR.aluResult, readData: readDataM,
                  rd: memR.rd, pcPlus4: memR.pcPlus4};
  end

  // Writeback select
  always_comb begin
    case (wbR.resultSel)
      resMem:     resultW = wbR.readData;
      resPcPlus4: resultW = wbR.pcPlus4;   // jal link
      default:    resultW = wbR.aluResult;
    endcase
  end

  // Branch and jump targets keep fetch aligned
  assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00);

endmodule

// ==== hdl/rv_params.svh ====
`ifndef RV_PARAMS_SVH
`define RV_PARAMS_SVH

// ==========================================================================
// Core sizing
// ==========================================================================

// Data path and address width
`define XLEN 32

// Integer registers including x0
`define NREGS 32

// Data memory depth in words
`define DMEM_WORDS 64

`endif

// ==== verif/rvModel.svh ====
`ifndef RV_MODEL_SVH
`define RV_MODEL_SVH

// ==========================================================================
// Random source
// ==========================================================================
logic [31:0] lfsr;

// Fibonacci LFSR, taps 32 22 2 1, one step per bit drawn
function automatic logic [31:0] nextBits(input int n);
  logic [31:0] v;
  logic        fb;
  v = '0;
  for (int k = 0; k < n; k++) begin
    fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
    lfsr = {lfsr[30:0], fb};
    v    = {v[30:0], fb};
  end
  return v;
endfunction

// ==========================================================================
// Instruction encoders
// ==========================================================================
function automatic logic [31:0] rWord(input logic [6:0] f7, input logic [2:0] f3,
                                      input logic [4:0] rd, rs1, rs2);
  return {f7, rs2, rs1, f3, rd, opReg};
endfunction

function automatic logic [31:0] iWord(input logic [2:0] f3, input logic [4:0] rd, rs1,
                                      input logic [11:0] imm);
  return {imm, rs1, f3, rd, opImm};
endfunction

function automatic logic [31:0] lwWord(input logic [4:0] rd, rs1, input logic [11:0] imm);
  return {imm, rs1, 3'b010, rd, opLoad};
endfunction

function automatic logic [31:0] swWord(input logic [4:0] rs2, rs1, input logic [11:0] imm);
  return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], opStore};
endfunction

function automatic logic [31:0] beqWord(input logic [4:0] rs1, rs2, input logic [12:0] imm);
  return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], opBranch};
endfunction

function automatic logic [31:0] jalWord(input logic [4:0] rd, input logic [20:0] imm);
  return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opJal};
endfunction

// Op select 0..4 is add sub and or slt
function automatic logic [2:0] funct3For(input logic [2:0] sel);
  case (sel)
    3'd2:    return 3'b111;
    3'd3:    return 3'b110;
    3'd4:    return 3'b010;
    default: return 3'b000;  // add, sub
  endcase
endfunction

// ==========================================================================
// Program generator
// ==========================================================================
task automatic buildRandomProgram();
  int          endIdx;
  logic [2:0]  kind, sel;
  logic [4:0]  rd, rs1, rs2;
  logic [12:0] hop;
  // x1..x7 get a value before anything reads them
  for (int r = 1; r < 8; r++)
    emit(iWord(3'b000, 5'(r), 5'd0, 12'(nextBits(12))));
  endIdx = progLen + 16 + int'(nextBits(4));   // Index of the self jump
  while (progLen < endIdx) begin
    kind = 3'(nextBits(3));
    rd   = 5'(nextBits(3));
    rs1  = 5'(nextBits(3));
    rs2  = 5'(nextBits(3));
    hop  = 13'((2 + nextBits(2) % 3) * 4);     // 2 to 4 words forward
    if ((kind == 3'd4 || kind == 3'd5) && progLen + 4 > endIdx)
      kind = 3'd0;                              // Would land past the end
    case (kind)
      3'd1: begin
        sel = 3'(nextBits(3) % 5);
        emit(iWord(funct3For(sel), rd, rs1, 12'(nextBits(12))));
      end
      3'd2:       emit(lwWord(rd, 5'd0, {4'b0000, 6'(nextBits(6)), 2'b00}));
      3'd3, 3'd6: emit(swWord(rs2, 5'd0, {4'b0000, 6'(nextBits(6)), 2'b00}));
      3'd4:       emit(beqWord(rs1, rs2, hop));
      3'd5:       emit(jalWord(rd, 21'(hop)));
      default: begin
        sel = 3'(nextBits(3) % 5);
        emit(rWord((sel == 3'd1) ? 7'h20 : 7'h00, funct3For(sel), rd, rs1, rs2));
      end
    endcase
  end
  emit(jalWord(5'd0, 21'd0));   // Program end
endtask

// ==========================================================================
// ISA reference
// ==========================================================================
logic [31:0] refRegs [32];
logic [31:0] refMem  [`DMEM_WORDS];

function automatic logic [31:0] aluRef(input logic [2:0] f3, input logic isSub,
                                       input logic [31:0] a, b);
  case (f3)
    3'b111:  return a & b;
    3'b110:  return a | b;
    3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    default: return isSub ? a - b : a + b;
  endcase
endfunction

// Runs progMem up to the self jump and lists every store in order
function automatic int runReference();
  logic [31:0] w, a, b, ea, pcRef, nextPc;
  int          n;
  n     = 0;
  pcRef = '0;
  for (int k = 0; k < 32; k++)
    refRegs[k] = '0;
  for (int k = 0; k < `DMEM_WORDS; k++)
    refMem[k] = '0;                       // Data memory resets to zero
  for (int step = 0; step < 4096; step++) begin
    w      = progMem[pcRef[9:2]];
    a      = refRegs[w[19:15]];
    b      = refRegs[w[24:20]];
    nextPc = pcRef + 32'd4;
    case (w[6:0])
      opLoad: begin
        ea               = a + {{20{w[31]}}, w[31:20]};
        refRegs[w[11:7]] = refMem[ea[7:2]];
      end
      opStore: begin
        ea              = a + {{20{w[31]}}, w[31:25], w[11:7]};
        refMem[ea[7:2]] = b;
        expAdr[n]       = ea;
        expData[n]      = b;
        n++;
      end
      opReg: refRegs[w[11:7]] = aluRef(w[14:12], w[30], a, b);
      opImm: refRegs[w[11:7]] = aluRef(w[14:12], 1'b0, a, {{20{w[31]}}, w[31:20]});
      opBranch: begin
        if (a == b)
          nextPc = pcRef + {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
      end
      opJal: begin
        refRegs[w[11:7]] = pcRef + 32'd4;   // Link
        if (w[31:12] == '0)
          return n;                         // Jump to itself
        nextPc = pcRef + {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
      end
      default: ;
    endcase
    refRegs[0] = '0;
    pcRef      = nextPc;
  end
  $display("Reference model never reached the closing self jump");
  otherErrs++;
  return n;
endfunction

`endif

// ==== verif/rvTestbench.sv ====
`timescale 1ns/1ps
`include "rv_params.svh"

module rvTestbench
  import rvIsaPkg::*;
();

  localparam logic [31:0] SEED   = 32'hcf36;
  localparam logic [31:0] NOP    = 32'h00000013;  // addi x0, x0, 0
  localparam int          NRAND  = 20;
  localparam int          MAXLEN = 40;            // Longest generated program
  localparam int          NPROG  = NRAND + 3;
  // Reset, run budget and end check per program, plus slack
  localparam int WATCHDOG_CYC = NPROG * (5 + 3 * MAXLEN + 20 + 3) + 200;

  logic             clk;
  logic             reset;
  logic [`XLEN-1:0] pc, instr;
  logic             memWrite;
  logic [`XLEN-1:0] dataAdr, writeData;

  logic [31:0] progMem [256];
  int          progLen, progNum;
  logic [31:0] expAdr  [256];   // Expected stores, in program order
  logic [31:0] expData [256];
  int          expCount, seenCount;
  logic        checking;        // Compare window of the current program
  int          valueErrs, otherErrs;

  task automatic emit(input logic [31:0] word);
    progMem[progLen] = word;
    progLen++;
  endtask

  `include "rvModel.svh"

  rvPipeCore dut0 (
    .clk(clk), .reset(reset), .pc(pc), .instr(instr),
    .memWrite(memWrite), .dataAdr(dataAdr), .writeData(writeData)
  );

  assign instr = progMem[pc[9:2]];   // Program store answers in the same cycle

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // ==========================================================================
  // Program control
  // ==========================================================================
  task automatic clearProgram();
    for (int k = 0; k < 256; k++)
      progMem[k] = NOP;             // Fetches past the end see nops
    progLen = 0;
  endtask

  task automatic holdReset();
    @(posedge clk);
    reset    <= 1'b1;
    checking <= 1'b0;
    repeat (4) begin
      @(negedge clk);
      if (memWrite !== 1'b0 || pc !== '0) begin
        $display("Store or nonzero pc seen while reset is held");
        otherErrs++;
      end
    end
    clearProgram();
  endtask

  task automatic runLoaded();
    int budget;
    budget    = 3 * progLen + 20;
    expCount  = runReference();
    seenCount = 0;
    progNum++;
    checking <= 1'b1;
    @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    // First cycle out of reset still fetches address 0
    if (memWrite !== 1'b0 || pc !== '0) begin
      $display("Program %0d does not start at pc 0 without a store", progNum);
      otherErrs++;
    end
    repeat (budget) @(posedge clk);
    checking <= 1'b0;
    @(negedge clk);
    if (seenCount != expCount) begin
      $display("Program %0d made %0d stores where %0d were expected",
               progNum, seenCount, expCount);
      otherErrs++;
    end
  endtask

  // Dependent ALU chain, every result stored at once
  task automatic buildAluProgram();
    emit(iWord(3'b000, 5'd1, 5'd0, 12'd5));         // addi x1, x0, 5
    emit(iWord(3'b000, 5'd2, 5'd0, 12'hffd));       // addi x2, x0, -3
    emit(rWord(7'h00, 3'b000, 5'd3, 5'd1, 5'd2));   // add
    emit(swWord(5'd3, 5'd0, 12'd0));
    emit(rWord(7'h20, 3'b000, 5'd4, 5'd3, 5'd1));   // sub
    emit(swWord(5'd4, 5'd0, 12'd4));
    emit(rWord(7'h00, 3'b111, 5'd5, 5'd4, 5'd2));   // and
    emit(swWord(5'd5, 5'd0, 12'd8));
    emit(rWord(7'h00, 3'b110, 5'd6, 5'd5, 5'd3));   // or
    emit(swWord(5'd6, 5'd0, 12'd12));
    emit(rWord(7'h00, 3'b010, 5'd7, 5'd2, 5'd1));   // slt, negative vs positive
    emit(swWord(5'd7, 5'd0, 12'd16));
    emit(iWord(3'b111, 5'd1, 5'd4, 12'h0f0));       // andi
    emit(swWord(5'd1, 5'd0, 12'd20));
    emit(iWord(3'b110, 5'd2, 5'd1, 12'h00f));       // ori
    emit(swWord(5'd2, 5'd0, 12'd24));
    emit(iWord(3'b010, 5'd3, 5'd2, 12'h7ff));       // slti
    emit(swWord(5'd3, 5'd0, 12'd28));
    emit(jalWord(5'd0, 21'd0));
  endtask

  // Load-use pairs, then writes to x0
  task automatic buildLoadProgram();
    emit(iWord(3'b000, 5'd1, 5'd0, 12'h123));
    emit(swWord(5'd1, 5'd0, 12'd32));
    emit(lwWord(5'd2, 5'd0, 12'd32));
    emit(rWord(7'h00, 3'b000, 5'd3, 5'd2, 5'd1));   // Uses the load at once
    emit(swWord(5'd3, 5'd0, 12'd36));
    emit(lwWord(5'd4, 5'd0, 12'd36));
    emit(swWord(5'd4, 5'd0, 12'd40));               // Store data from a load
    emit(iWord(3'b000, 5'd0, 5'd1, 12'd3));
    emit(rWord(7'h00, 3'b000, 5'd0, 5'd1, 5'd1));
    emit(swWord(5'd0, 5'd0, 12'd44));               // x0 must still read zero
    emit(jalWord(5'd0, 21'd0));
  endtask

  // Stores sit in every slot that a taken jump skips
  task automatic buildBranchProgram();
    emit(iWord(3'b000, 5'd1, 5'd0, 12'd1));
    emit(iWord(3'b000, 5'd2, 5'd0, 12'd1));
    emit(iWord(3'b000, 5'd3, 5'd0, 12'd2));
    emit(beqWord(5'd1, 5'd2, 13'd12));              // Taken
    emit(swWord(5'd1, 5'd0, 12'd0));
    emit(swWord(5'd1, 5'd0, 12'd4));
    emit(swWord(5'd3, 5'd0, 12'd8));
    emit(beqWord(5'd1, 5'd3, 13'd8));               // Not taken
    emit(swWord(5'd2, 5'd0, 12'd12));
    emit(swWord(5'd3, 5'd0, 12'd16));
    emit(jalWord(5'd5, 21'd12));
    emit(swWord(5'd1, 5'd0, 12'd20));
    emit(swWord(5'd1, 5'd0, 12'd24));
    emit(swWord(5'd5, 5'd0, 12'd28));               // Link value
    emit(jalWord(5'd0, 21'd0));
  endtask

  // ==========================================================================
  // Main sequence
  // ==========================================================================
  initial begin
    reset     = 1'b1;     // Held from time zero
    checking  = 1'b0;
    lfsr      = SEED;
    valueErrs = 0;
    otherErrs = 0;
    progNum   = 0;
    clearProgram();
    holdReset();
    buildAluProgram();
    runLoaded();
    holdReset();
    buildLoadProgram();
    runLoaded();
    holdReset();
    buildBranchProgram();
    runLoaded();
    for (int p = 0; p < NRAND; p++) begin
      holdReset();
      buildRandomProgram();
      runLoaded();
    end
    $display("Errors: %0d value mismatches, %0d other failures", valueErrs, otherErrs);
    if (valueErrs + otherErrs == 0)
      $display("All checks passed");
    else
      $display("Checks failed");
    $finish;
  end

  // Store compare, one store per cycle at most
  always @(posedge clk) begin
    if (checking && memWrite) begin
      if (seenCount < expCount) begin
        if (dataAdr !== expAdr[seenCount]) begin
          $display("ERR dataAdr got %h expected %h", dataAdr, expAdr[seenCount]);
          valueErrs++;
        end
        if (writeData !== expData[seenCount]) begin
          $display("ERR writeData got %h expected %h", writeData, expData[seenCount]);
          valueErrs++;
        end
      end
      seenCount++;
    end
  end

  // Watchdog
  initial begin
    repeat (WATCHDOG_CYC) @(posedge clk);
    $display("Timeout, the run did not end within %0d cycles", WATCHDOG_CYC);
    $display("Checks failed");
    $finish;
  end

endmodule
